// ==== verilog/replay_pkg.sv ====
/*
 * Packet capture and replay engine, shared definitions
 * Stream widths, memory geometry, stored word layout, per-queue region map
 * and the rule that maps a destination port field to a queue index.
 */
package replay_pkg;

  localparam int DATA_W       = 64;
  localparam int STRB_W       = 8;
  localparam int TUSER_W      = 32;
  localparam int DST_PORT_POS = 24;
  localparam int DST_PORT_W   = 8;
  localparam int NUM_QUEUES   = 4;
  localparam int QID_W        = 2;
  localparam int ADDR_W       = 8;

  // Output buffer of the reader
  localparam int OBUF_DEPTH   = 4;
  localparam int OBUF_PTR_W   = 2;

  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [STRB_W-1:0]  strb_t;
  typedef logic [TUSER_W-1:0] tuser_t;
  typedef logic [QID_W-1:0]   qid_t;
  typedef logic [ADDR_W-1:0]  mem_addr_t;

  // One stored word
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } mem_word_t;

  typedef struct packed {
    mem_word_t word;
    qid_t      qid;
  } cap_word_t;

  // Inclusive bounds
  typedef struct packed {
    mem_addr_t high;
    mem_addr_t low;
  } region_cfg_t;

  typedef region_cfg_t [NUM_QUEUES-1:0] region_map_t;
  typedef mem_addr_t [NUM_QUEUES-1:0]   ptr_map_t;

  // Lowest set bit among port bits 0, 2, 4, 6 picks the queue, none gives 0
  function automatic qid_t port_to_qid(input tuser_t tuser);
    logic [DST_PORT_W-1:0] port;
    qid_t                  qid;
    port = tuser[DST_PORT_POS +: DST_PORT_W];
    qid  = '0;
    for (int i = NUM_QUEUES - 1; i >= 0; i--) begin
      if (port[2*i]) begin
        qid = qid_t'(i);
      end
    end
    return qid;
  endfunction

  // Queue index back to its one-hot destination port in tuser
  function automatic tuser_t qid_to_tuser(input qid_t qid);
    return tuser_t'(1) << (DST_PORT_POS + 2 * int'(qid));
  endfunction

endpackage

// ==== verilog/stream_capture.sv ====
/*
 * Stream capture
 * Accepts AXI-stream words, registers them and tags every word with the
 * queue decoded from the destination port of its packet's first word.
 */
module stream_capture (
  input  logic                  axi_aclk,
  input  logic                  arst_n,
  input  logic                  sw_rst,
  input  replay_pkg::data_t     s_axis_tdata,
  input  replay_pkg::strb_t     s_axis_tstrb,
  input  replay_pkg::tuser_t    s_axis_tuser,
  input  logic                  s_axis_tvalid,
  input  logic                  s_axis_tlast,
  output logic                  s_axis_tready,
  output replay_pkg::cap_word_t cap_word,
  output logic                  cap_valid
);

  logic             ready_q;
  logic             sop;
  logic             accept;
  replay_pkg::qid_t qid_q;
  replay_pkg::qid_t qid_now;

  // Always ready once out of reset
  assign s_axis_tready = ready_q & ~sw_rst;
  assign accept        = s_axis_tvalid & s_axis_tready;

  // First word decodes, the rest of the packet reuses the latched queue
  assign qid_now = sop ? replay_pkg::port_to_qid(s_axis_tuser) : qid_q;

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      ready_q   <= 1'b0;
      sop       <= 1'b1;
      qid_q     <= '0;
      cap_valid <= 1'b0;
    end else begin
      ready_q <= 1'b1;
      if (sw_rst) begin
        sop       <= 1'b1;
        cap_valid <= 1'b0;
      end else begin
        cap_valid <= accept;
        if (accept) begin
          sop   <= s_axis_tlast;
          qid_q <= qid_now;
        end
      end
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (accept) begin
      cap_word.word.data <= s_axis_tdata;
      cap_word.word.strb <= s_axis_tstrb;
      cap_word.word.last <= s_axis_tlast;
      cap_word.qid       <= qid_now;
    end
  end

endmodule

// ==== verilog/region_writer.sv ====
/*
 * Region writer
 * Keeps a write pointer, a commit pointer and a drop flag per queue and
 * writes captured words into the queue's region of the word memory.
 * A packet that runs past its region's high bound is dropped whole and
 * the write pointer falls back to the last committed packet end.
 */
module region_writer (
  input  logic                    axi_aclk,
  input  logic                    arst_n,
  input  logic                    sw_rst,
  input  replay_pkg::region_map_t regions,
  input  replay_pkg::cap_word_t   cap_word,
  input  logic                    cap_valid,
  output logic                    wr_en,
  output replay_pkg::mem_addr_t   wr_addr,
  output replay_pkg::mem_word_t   wr_word,
  output replay_pkg::ptr_map_t    commit_end
);

  // Pointers are kept as offsets from each region's low bound
  replay_pkg::ptr_map_t                   wr_off;
  replay_pkg::ptr_map_t                   commit_off;
  logic [replay_pkg::NUM_QUEUES-1:0]      drop;

  replay_pkg::qid_t       q;
  replay_pkg::mem_addr_t  cur_off;
  replay_pkg::mem_addr_t  next_off;
  replay_pkg::mem_addr_t  span;
  logic                   fits;
  logic                   is_last;

  assign q        = cap_word.qid;
  assign is_last  = cap_word.word.last;
  assign cur_off  = wr_off[q];
  assign next_off = cur_off + 1'b1;

  // Last valid offset inside the region
  assign span = regions[q].high - regions[q].low;
  assign fits = ~drop[q] && (cur_off <= span);

  assign wr_en   = cap_valid && fits;
  assign wr_addr = regions[q].low + cur_off;
  assign wr_word = cap_word.word;

  // Next free address after the last complete packet
  always_comb begin
    for (int i = 0; i < replay_pkg::NUM_QUEUES; i++) begin
      commit_end[i] = regions[i].low + commit_off[i];
    end
  end

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_off     <= '0;
      commit_off <= '0;
      drop       <= '0;
    end else if (sw_rst) begin
      wr_off     <= '0;
      commit_off <= '0;
      drop       <= '0;
    end else if (cap_valid) begin
      if (fits) begin
        wr_off[q] <= next_off;
        if (is_last) begin
          commit_off[q] <= next_off;
        end
      end else if (is_last) begin
        // End of an overflowing packet, rewind to the committed end
        wr_off[q] <= commit_off[q];
        drop[q]   <= 1'b0;
      end else begin
        drop[q] <= 1'b1;
      end
    end
  end

endmodule

// ==== verilog/replay_memory.sv ====
/*
 * Replay memory
 * Dual-port word store for all queue regions, one write port and one
 * registered read port with a single cycle of read latency.
 */
module replay_memory (
  input  logic                  axi_aclk,
  input  logic                  wr_en,
  input  replay_pkg::mem_addr_t wr_addr,
  input  replay_pkg::mem_word_t wr_word,
  input  logic                  rd_en,
  input  replay_pkg::mem_addr_t rd_addr,
  output replay_pkg::mem_word_t rd_word
);

  replay_pkg::mem_word_t mem [2**replay_pkg::ADDR_W];

  always_ff @(posedge axi_aclk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_word;
    end
  end

  // Read data holds until the next read
  always_ff @(posedge axi_aclk) begin
    if (rd_en) begin
      rd_word <= mem[rd_addr];
    end
  end

endmodule

// ==== verilog/replay_reader.sv ====
/*
 * Replay reader
 * On a start pulse reads one queue's committed words from the memory and
 * sends them out as an AXI stream. A small output buffer plus the read in
 * flight is sized so that a read is only issued when its word has room.
 */
module replay_reader (
  input  logic                    axi_aclk,
  input  logic                    arst_n,
  input  logic                    sw_rst,
  input  logic                    replay_start,
  input  replay_pkg::qid_t        replay_qid,
  output logic                    replay_busy,
  input  replay_pkg::region_map_t regions,
  input  replay_pkg::ptr_map_t    commit_end,
  output logic                    rd_en,
  output replay_pkg::mem_addr_t   rd_addr,
  input  replay_pkg::mem_word_t   rd_word,
  output replay_pkg::data_t       m_axis_tdata,
  output replay_pkg::strb_t       m_axis_tstrb,
  output replay_pkg::tuser_t      m_axis_tuser,
  output logic                    m_axis_tvalid,
  input  logic                    m_axis_tready,
  output logic                    m_axis_tlast
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_DRAIN
  } replay_state_t;

  replay_state_t         state;
  replay_pkg::qid_t      qid_q;
  replay_pkg::mem_addr_t rd_ptr;
  replay_pkg::mem_addr_t end_ptr;

  // Read issued last cycle, its word lands in the buffer now
  logic inflight;

  replay_pkg::mem_word_t                obuf [replay_pkg::OBUF_DEPTH];
  logic [replay_pkg::OBUF_PTR_W-1:0]    obuf_wr;
  logic [replay_pkg::OBUF_PTR_W-1:0]    obuf_rd;
  logic [replay_pkg::OBUF_PTR_W:0]      obuf_cnt;
  logic [replay_pkg::OBUF_PTR_W:0]      reserved;

  logic more;
  logic space;
  logic pop;

  assign more     = rd_ptr != end_ptr;
  assign reserved = obuf_cnt + {{replay_pkg::OBUF_PTR_W{1'b0}}, inflight};
  assign space    = reserved < replay_pkg::OBUF_DEPTH;

  assign rd_en   = (state == ST_READ) && more && space;
  assign rd_addr = rd_ptr;

  assign replay_busy = state != ST_IDLE;

  assign m_axis_tvalid = obuf_cnt != '0;
  assign pop           = m_axis_tvalid & m_axis_tready;
  assign m_axis_tdata  = obuf[obuf_rd].data;
  assign m_axis_tstrb  = obuf[obuf_rd].strb;
  assign m_axis_tlast  = obuf[obuf_rd].last;
  assign m_axis_tuser  = replay_pkg::qid_to_tuser(qid_q);

  always_ff @(posedge axi_aclk) begin
    if (inflight) begin
      obuf[obuf_wr] <= rd_word;
    end
  end

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= ST_IDLE;
      qid_q    <= '0;
      rd_ptr   <= '0;
      end_ptr  <= '0;
      inflight <= 1'b0;
      obuf_wr  <= '0;
      obuf_rd  <= '0;
      obuf_cnt <= '0;
    end else if (sw_rst) begin
      // Abandon the replay and flush buffered beats
      state    <= ST_IDLE;
      inflight <= 1'b0;
      obuf_wr  <= '0;
      obuf_rd  <= '0;
      obuf_cnt <= '0;
    end else begin
      inflight <= rd_en;
      if (inflight) begin
        obuf_wr <= obuf_wr + 1'b1;
      end
      if (pop) begin
        obuf_rd <= obuf_rd + 1'b1;
      end
      obuf_cnt <= obuf_cnt + {{replay_pkg::OBUF_PTR_W{1'b0}}, inflight}
                           - {{replay_pkg::OBUF_PTR_W{1'b0}}, pop};
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      case (state)
        ST_IDLE: begin
          if (replay_start) begin
            qid_q   <= replay_qid;
            rd_ptr  <= regions[replay_qid].low;
            end_ptr <= commit_end[replay_qid];
            state   <= ST_READ;
          end
        end
        ST_READ: begin
          if (!more) begin
            state <= ST_DRAIN;
          end
        end
        ST_DRAIN: begin
          // Done once nothing is pending and the last beat has left
          if (!inflight && obuf_cnt == '0) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== verilog/pcap_replay_top.sv ====
/*
 * Packet capture and replay engine, top level
 * Input stream is split into four queues held in regions of one word
 * memory. A start pulse replays the committed packets of one queue as an
 * output stream.
 */
module pcap_replay_top (
  input  logic                    axi_aclk,
  input  logic                    arst_n,
  input  logic                    sw_rst,

  // Capture stream
  input  replay_pkg::data_t       s_axis_tdata,
  input  replay_pkg::strb_t       s_axis_tstrb,
  input  replay_pkg::tuser_t      s_axis_tuser,
  input  logic                    s_axis_tvalid,
  output logic                    s_axis_tready,
  input  logic                    s_axis_tlast,

  // Replay stream
  output replay_pkg::data_t       m_axis_tdata,
  output replay_pkg::strb_t       m_axis_tstrb,
  output replay_pkg::tuser_t      m_axis_tuser,
  output logic                    m_axis_tvalid,
  input  logic                    m_axis_tready,
  output logic                    m_axis_tlast,

  input  replay_pkg::region_map_t regions,
  input  logic                    replay_start,
  input  replay_pkg::qid_t        replay_qid,
  output logic                    replay_busy
);

  replay_pkg::cap_word_t cap_word;
  logic                  cap_valid;

  logic                  wr_en;
  replay_pkg::mem_addr_t wr_addr;
  replay_pkg::mem_word_t wr_word;
  replay_pkg::ptr_map_t  commit_end;

  logic                  rd_en;
  replay_pkg::mem_addr_t rd_addr;
  replay_pkg::mem_word_t rd_word;

  stream_capture stream_capture_i (
    .axi_aclk      (axi_aclk),
    .arst_n        (arst_n),
    .sw_rst        (sw_rst),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tstrb  (s_axis_tstrb),
    .s_axis_tuser  (s_axis_tuser),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tlast  (s_axis_tlast),
    .s_axis_tready (s_axis_tready),
    .cap_word      (cap_word),
    .cap_valid     (cap_valid)
  );

  region_writer region_writer_i (
    .axi_aclk   (axi_aclk),
    .arst_n     (arst_n),
    .sw_rst     (sw_rst),
    .regions    (regions),
    .cap_word   (cap_word),
    .cap_valid  (cap_valid),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_word    (wr_word),
    .commit_end (commit_end)
  );

  replay_memory replay_memory_i (
    .axi_aclk (axi_aclk),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_word  (wr_word),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_word  (rd_word)
  );

  replay_reader replay_reader_i (
    .axi_aclk      (axi_aclk),
    .arst_n        (arst_n),
    .sw_rst        (sw_rst),
    .replay_start  (replay_start),
    .replay_qid    (replay_qid),
    .replay_busy   (replay_busy),
    .regions       (regions),
    .commit_end    (commit_end),
    .rd_en         (rd_en),
    .rd_addr       (rd_addr),
    .rd_word       (rd_word),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tstrb  (m_axis_tstrb),
    .m_axis_tuser  (m_axis_tuser),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast)
  );

endmodule

// ==== sim/pcap_replay_checker.sv ====
/*
 * Replay stream checker
 * Concurrent assertions on the output stream and the busy flag of the
 * capture and replay engine, bound into the top level.
 */
module pcap_replay_checker (
  input logic               axi_aclk,
  input logic               arst_n,
  input logic               sw_rst,
  input replay_pkg::data_t  m_axis_tdata,
  input replay_pkg::strb_t  m_axis_tstrb,
  input replay_pkg::tuser_t m_axis_tuser,
  input logic               m_axis_tvalid,
  input logic               m_axis_tready,
  input logic               m_axis_tlast,
  input logic               replay_busy
);
  timeunit 1ns;
  timeprecision 100ps;

  // Even destination port bits in tuser
  localparam replay_pkg::tuser_t EVEN_PORTS =
    replay_pkg::tuser_t'(8'h55) << replay_pkg::DST_PORT_POS;

  // Raised by any failing assertion, watched by the testbench
  logic error_seen = 1'b0;

  // A stalled beat holds until it is taken
  hold_a: assert property (@(posedge axi_aclk) disable iff (!arst_n || sw_rst)
      m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata) &&
      $stable(m_axis_tstrb) && $stable(m_axis_tlast))
    else begin
      error_seen = 1'b1;
      $error("Output beat changed while the stream was stalled");
    end

  busy_a: assert property (@(posedge axi_aclk) disable iff (!arst_n)
      m_axis_tvalid |-> replay_busy)
    else begin
      error_seen = 1'b1;
      $error("m_axis_tvalid high while replay_busy is low");
    end

  tuser_a: assert property (@(posedge axi_aclk) disable iff (!arst_n)
      $onehot(m_axis_tuser) && ((m_axis_tuser & ~EVEN_PORTS) == '0))
    else begin
      error_seen = 1'b1;
      $error("m_axis_tuser is not a single even destination port bit");
    end

  // First edge after reset release
  reset_a: assert property (@(posedge axi_aclk)
      $rose(arst_n) |-> !replay_busy && !m_axis_tvalid)
    else begin
      error_seen = 1'b1;
      $error("Replay active in the cycle after reset release");
    end

endmodule

bind pcap_replay_top pcap_replay_checker checker_i (.*);

// ==== sim/pcap_replay_tb.sv ====
/*
 * Testbench for the packet capture and replay engine
 * Captures packets into the four queue regions, replays each queue and
 * compares every output beat with a per-queue model of committed packets.
 */
module pcap_replay_tb;
  timeunit 1ns;
  timeprecision 100ps;

  logic                    axi_aclk;
  logic                    arst_n;
  logic                    sw_rst;
  replay_pkg::data_t       s_axis_tdata;
  replay_pkg::strb_t       s_axis_tstrb;
  replay_pkg::tuser_t      s_axis_tuser;
  logic                    s_axis_tvalid;
  logic                    s_axis_tready;
  logic                    s_axis_tlast;
  replay_pkg::data_t       m_axis_tdata;
  replay_pkg::strb_t       m_axis_tstrb;
  replay_pkg::tuser_t      m_axis_tuser;
  logic                    m_axis_tvalid;
  logic                    m_axis_tready;
  logic                    m_axis_tlast;
  replay_pkg::region_map_t regions;
  logic                    replay_start;
  replay_pkg::qid_t        replay_qid;
  logic                    replay_busy;

  // Committed words per queue as {data, strb, last}
  logic [72:0] model_mem [4][64];
  int          model_cnt [4];
  int          region_words [4];
  logic [31:0] lcg_state;

  pcap_replay_top pcap_replay_top_i (.*);

  initial begin
    axi_aclk = 1'b0;
    forever #2 axi_aclk = ~axi_aclk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Lowest of port bits 0, 2, 4, 6 names the queue, none of them means queue 0
  function automatic int decode_queue(input logic [7:0] port);
    for (int i = 0; i < 4; i++) begin
      if (port[2*i]) begin
        return i;
      end
    end
    return 0;
  endfunction

  function automatic logic [31:0] port_tuser(input int q);
    return 32'h1 << (24 + 2 * q);
  endfunction

  task automatic step();
    @(posedge axi_aclk);
    #1;
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    report_failure($sformatf("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h",
                             $time, name, got, exp));
  endtask

  task automatic wait_input_ready();
    int n;
    n = 0;
    while (!s_axis_tready) begin
      if (n == 50) begin
        report_failure("Input stream did not become ready within 50 cycles");
      end
      step();
      n++;
    end
  endtask

  task automatic send_packet(input logic [7:0] port, input int len);
    int          q;
    bit          keep;
    logic [31:0] rnd;
    logic [63:0] data;
    logic [7:0]  strb;
    q    = decode_queue(port);
    keep = (model_cnt[q] + len) <= region_words[q];
    for (int k = 0; k < len; k++) begin
      data = {next_rand(), next_rand()};
      rnd  = next_rand();
      strb = rnd[31:24];
      s_axis_tdata  = data;
      s_axis_tstrb  = strb;
      // Later words carry random port bits, only the first one counts
      s_axis_tuser  = {(k == 0) ? port : rnd[23:16], rnd[23:0]};
      s_axis_tlast  = (k == len - 1);
      s_axis_tvalid = 1'b1;
      wait_input_ready();
      step();
      if (keep) begin
        model_mem[q][model_cnt[q] + k] = {data, strb, s_axis_tlast};
      end
    end
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    if (keep) begin
      model_cnt[q] += len;
    end
  endtask

  task automatic run_replay(input int q, input bit random_ready, input int intrude_at);
    int          idx;
    int          cycles;
    logic [31:0] rnd;
    logic [72:0] exp_word;
    logic        ready;
    idx    = 0;
    cycles = 0;
    // Let the last captured words commit
    repeat (3) step();
    replay_qid   = replay_pkg::qid_t'(q);
    replay_start = 1'b1;
    step();
    replay_start = 1'b0;
    assert (replay_busy)
      else report_failure($sformatf("replay_busy did not rise for queue %0d", q));
    while (replay_busy) begin
      if (cycles == 2000) begin
        report_failure($sformatf("Replay of queue %0d did not finish in 2000 cycles", q));
      end
      rnd   = next_rand();
      ready = random_ready ? rnd[29] : 1'b1;
      m_axis_tready = ready;
      // Start pulse for another queue while busy
      replay_start = (cycles == intrude_at);
      replay_qid   = replay_pkg::qid_t'((cycles == intrude_at) ? q ^ 1 : q);
      if (m_axis_tvalid && ready) begin
        assert (idx < model_cnt[q])
          else report_failure($sformatf("Queue %0d replayed more words than stored", q));
        exp_word = model_mem[q][idx];
        assert (m_axis_tdata == exp_word[72:9])
          else report_mismatch("m_axis_tdata", m_axis_tdata, exp_word[72:9]);
        assert (m_axis_tstrb == exp_word[8:1])
          else report_mismatch("m_axis_tstrb", m_axis_tstrb, exp_word[8:1]);
        assert (m_axis_tlast == exp_word[0])
          else report_mismatch("m_axis_tlast", m_axis_tlast, exp_word[0]);
        assert (m_axis_tuser == port_tuser(q))
          else report_mismatch("m_axis_tuser", m_axis_tuser, port_tuser(q));
        idx++;
      end
      step();
      cycles++;
    end
    replay_start = 1'b0;
    assert (idx == model_cnt[q])
      else report_failure($sformatf("Queue %0d replayed %0d of %0d stored words",
                                    q, idx, model_cnt[q]));
    // Nothing may follow the finished replay
    repeat (8) begin
      assert (!replay_busy && !m_axis_tvalid)
        else report_failure($sformatf("Unexpected replay activity after queue %0d", q));
      step();
    end
  endtask

  always @(posedge axi_aclk) begin
    if (pcap_replay_top_i.checker_i.error_seen) begin
      report_failure("A protocol assertion on the replay stream failed");
    end
  end

  initial begin
    int          base;
    logic [31:0] rnd;
    logic [7:0]  mixed_ports [9];
    lcg_state     = 32'd47;
    arst_n        = 1'b0;
    sw_rst        = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tstrb  = '0;
    s_axis_tuser  = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast  = 1'b0;
    m_axis_tready = 1'b0;
    replay_start  = 1'b0;
    replay_qid    = '0;
    mixed_ports   = '{8'h00, 8'h02, 8'h04, 8'h0C, 8'h10, 8'h50, 8'h40, 8'hFF, 8'h8A};
    // Regions of 16, 24, 32 and 40 words placed back to back
    base = 0;
    for (int i = 0; i < 4; i++) begin
      region_words[i]  = 16 + 8 * i;
      regions[i].low   = replay_pkg::mem_addr_t'(base);
      regions[i].high  = replay_pkg::mem_addr_t'(base + region_words[i] - 1);
      base            += region_words[i];
      model_cnt[i]     = 0;
    end
    repeat (4) @(posedge axi_aclk);
    #1;
    arst_n = 1'b1;
    // Input stream stays closed until the first edge after release
    assert (!s_axis_tready)
      else report_mismatch("s_axis_tready", s_axis_tready, 1'b0);
    step();
    assert (s_axis_tready)
      else report_mismatch("s_axis_tready", s_axis_tready, 1'b1);

    // One queue, packets of 1 to 6 words
    for (int n = 1; n <= 6; n++) begin
      send_packet(8'h04, n);
    end
    run_replay(1, 1'b0, -1);

    // Mixed port fields, some with no even bit set
    foreach (mixed_ports[i]) begin
      rnd = next_rand();
      send_packet(mixed_ports[i], 1 + int'(rnd[31:30]));
    end
    for (int i = 0; i < 6; i++) begin
      rnd = next_rand();
      send_packet(rnd[31:24], 1 + int'(rnd[23:22]));
    end
    for (int q = 0; q < 4; q++) begin
      run_replay(q, 1'b1, (q == 1) ? 3 : -1);
    end

    // Software reset empties every region
    sw_rst = 1'b1;
    step();
    assert (!s_axis_tready)
      else report_mismatch("s_axis_tready", s_axis_tready, 1'b0);
    sw_rst = 1'b0;
    for (int q = 0; q < 4; q++) begin
      model_cnt[q] = 0;
    end
    for (int q = 0; q < 4; q++) begin
      run_replay(q, 1'b1, -1);
    end

    // Queue 0 overflows on the fourth packet, the last one fits after the rewind
    send_packet(8'h01, 5);
    send_packet(8'h01, 5);
    send_packet(8'h01, 5);
    send_packet(8'h01, 4);
    send_packet(8'h01, 1);
    run_replay(0, 1'b1, -1);

    step();
    if (pcap_replay_top_i.checker_i.error_seen) begin
      report_failure("A protocol assertion on the replay stream failed");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

// ==== filelist.f ====
verilog/replay_pkg.sv
verilog/stream_capture.sv
verilog/region_writer.sv
verilog/replay_memory.sv
verilog/replay_reader.sv
verilog/pcap_replay_top.sv
sim/pcap_replay_checker.sv
sim/pcap_replay_tb.sv

// ==== Bender.yml ====
package:
  name: pcap_replay

sources:
  - files:
      - verilog/replay_pkg.sv
      - verilog/stream_capture.sv
      - verilog/region_writer.sv
      - verilog/replay_memory.sv
      - verilog/replay_reader.sv
      - verilog/pcap_replay_top.sv
  - target: simulation
    files:
      - sim/pcap_replay_checker.sv
      - sim/pcap_replay_tb.sv
